// ==== Makefile ====
# Verilator build and run of the memory front end testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mac_mem_front
FILELIST  ?= mac_mem_front.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/floppy_detect.sv ====
//==========================================================
// floppy image detection and disk activity LED
// at the end of a floppy download the final word offset
// tells a double sided from a single sided image, ejects
// empty the drive again, and disk activity is stretched
// for ACT_HOLD cycles to stay visible on the user LED
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module floppy_detect import mac_mem_pkg::*; #(
	parameter int ACT_HOLD = 500000
) (
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	input  wire logic        ioctl_download,
	input  wire logic [7:0]  ioctl_index,
	input  wire logic [24:0] ioctl_addr,
	input  wire logic [1:0]  disk_eject,
	input  wire logic [1:0]  disk_act,
	output logic      [1:0]  disk_ins,
	output logic      [1:0]  disk_sides,
	output logic             led_user
);

	localparam int CNT_W = $clog2(ACT_HOLD + 1);

	// bit 0 internal drive, bit 1 external drive
	logic [1:0]       ds_flag;
	logic [1:0]       ss_flag;
	logic [1:0]       drive_sel;
	logic             down_d;
	logic             dl_end;
	logic [23:0]      word_off;
	logic             img_ds;
	logic             img_ss;
	logic [CNT_W-1:0] act_cnt;

	//==========================================================
	// image size decode
	//==========================================================

	assign word_off  = ioctl_addr[24:1];
	assign dl_end    = down_d & ~ioctl_download;
	assign drive_sel = {ioctl_index == IDX_FLOPPY_EXT, ioctl_index == IDX_FLOPPY_INT};
	// the host address counts bytes, the offset counts words
	assign img_ds    = (word_off == 24'(DS_IMAGE_WORDS));
	assign img_ss    = (word_off == 24'(SS_IMAGE_WORDS));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			down_d  <= 1'b0;
			ds_flag <= 2'b00;
			ss_flag <= 2'b00;
		end else begin
			down_d <= ioctl_download;
			for (int i = 0; i < 2; i++) begin
				// an unknown size clears both flags
				if (dl_end && drive_sel[i]) begin
					ds_flag[i] <= img_ds;
					ss_flag[i] <= img_ss;
				end
				// eject wins over a download ending in the same cycle
				if (disk_eject[i]) begin
					ds_flag[i] <= 1'b0;
					ss_flag[i] <= 1'b0;
				end
			end
		end
	end

	assign disk_ins   = ds_flag | ss_flag;
	assign disk_sides = ds_flag;

	//==========================================================
	// activity stretch
	//==========================================================

	// reload on every active cycle, count down otherwise
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			act_cnt <= '0;
		end else if (|disk_act) begin
			act_cnt <= CNT_W'(ACT_HOLD);
		end else if (act_cnt != '0) begin
			act_cnt <= act_cnt - 1'b1;
		end
	end

	assign led_user = ioctl_download | (act_cnt != '0);

endmodule

`default_nettype wire

// ==== logic/image_loader.sv ====
//==========================================================
// host download assembler
// turns each host strobe into one byte swapped SDRAM word
// mapped into the ROM or floppy area by download index, and
// holds the host off with ioctl_wait until a download slot
// has written the word
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module image_loader import mac_mem_pkg::*; (
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	input  wire logic [7:0]  ioctl_index,
	input  wire logic        ioctl_wr,
	input  wire logic [24:0] ioctl_addr,
	input  wire word_t       ioctl_data,
	input  wire logic        dio_slot,
	output logic             ioctl_wait,
	output dio_word_t        dio
);

	// word offset of the current host byte address
	logic [23:0] word_off;
	// floppy images get a wider window than the ROM
	logic        is_floppy;
	dio_addr_t   map_addr;

	// pending word
	dio_addr_t   dio_addr_q;
	word_t       dio_data_q;
	logic        dio_write_q;
	// slot level one cycle back
	logic        slot_d;
	logic        slot_fall;

	assign word_off  = ioctl_addr[24:1];
	assign is_floppy = (ioctl_index == IDX_FLOPPY_INT) ||
		(ioctl_index == IDX_FLOPPY_EXT);

	//==========================================================
	// address mapping
	//==========================================================

	// floppy images land at word offset 0x80000 or 0x100000,
	// ROM images use index bit 6 to pick one of two ROM banks
	always_comb begin
		if (is_floppy) begin
			map_addr = {ioctl_index[1:0], word_off[18:0]};
		end else begin
			map_addr = {2'b00, ioctl_index[6], word_off[17:0]};
		end
	end

	// payload captured on every strobe
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			// host sends the low byte first
			dio_data_q <= {ioctl_data[7:0], ioctl_data[15:8]};
			dio_addr_q <= map_addr;
		end
	end

	//==========================================================
	// host handshake
	//==========================================================

	assign slot_fall = slot_d & ~dio_slot;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			slot_d      <= 1'b0;
			dio_write_q <= 1'b0;
			ioctl_wait  <= 1'b0;
		end else begin
			slot_d <= dio_slot;

			// write level only moves between slots
			if (!dio_slot) begin
				dio_write_q <= ioctl_wait;
			end

			if (ioctl_wr) begin
				ioctl_wait <= 1'b1;
			end

			// the slot that just ended has taken the word
			if (slot_fall && dio_write_q) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	assign dio.addr  = dio_addr_q;
	assign dio.data  = dio_data_q;
	assign dio.write = dio_write_q;

endmodule

`default_nettype wire

// ==== logic/mac_mem_front.sv ====
//==========================================================
// memory front end top level
// the download assembler and the floppy detector run side
// by side on the host stream, the port selector merges the
// download word with the chipset request onto the SDRAM
// ACT_HOLD sets the disk LED stretch in clock cycles
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module mac_mem_front import mac_mem_pkg::*; #(
	parameter int ACT_HOLD = 500000
) (
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	// host loader
	input  wire logic        ioctl_download,
	input  wire logic [7:0]  ioctl_index,
	input  wire logic        ioctl_wr,
	input  wire logic [24:0] ioctl_addr,
	input  wire word_t       ioctl_data,
	output logic             ioctl_wait,
	// download slot from the bus timing
	input  wire logic        dio_slot,
	input  wire logic        model,
	// chipset and SDRAM
	input  wire mem_req_t    mem_req,
	input  wire word_t       sdram_out,
	output sdram_req_t       sdram_req,
	output word_t            mem_rdata,
	// floppy drives
	input  wire logic [1:0]  disk_eject,
	input  wire logic [1:0]  disk_act,
	output logic      [1:0]  disk_ins,
	output logic      [1:0]  disk_sides,
	output logic             led_user
);

	// pending download word
	dio_word_t dio;

	image_loader u_image_loader (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.ioctl_index (ioctl_index),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_data  (ioctl_data),
		.dio_slot    (dio_slot),
		.ioctl_wait  (ioctl_wait),
		.dio         (dio)
	);

	// watches the same host stream for floppy images
	floppy_detect #(
		.ACT_HOLD (ACT_HOLD)
	) u_floppy_detect (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.disk_eject     (disk_eject),
		.disk_act       (disk_act),
		.disk_ins       (disk_ins),
		.disk_sides     (disk_sides),
		.led_user       (led_user)
	);

	sdram_port_mux u_sdram_port_mux (
		.ioctl_download (ioctl_download),
		.dio_slot       (dio_slot),
		.model          (model),
		.dio            (dio),
		.mem_req        (mem_req),
		.sdram_out      (sdram_out),
		.sdram_req      (sdram_req),
		.mem_rdata      (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/mac_mem_pkg.sv ====
//==========================================================
// shared types and constants of the memory front end
// covers sizes, floppy image word counts, SDRAM region
// prefixes, the SDRAM address union and the request structs
// imported by every module of the front end
//==========================================================
`default_nettype none

package mac_mem_pkg;

	//==========================================================
	// basic widths
	//==========================================================

	// one memory data word
	typedef logic [15:0] word_t;
	// chipset byte address
	typedef logic [21:0] mem_addr_t;
	// SDRAM word address
	typedef logic [24:0] sdram_addr_t;
	// word offset inside the download area
	typedef logic [20:0] dio_addr_t;

	//==========================================================
	// image sizes, regions and download indices
	//==========================================================

	// a double sided image is 819200 bytes, counted here in words
	localparam int DS_IMAGE_WORDS = 409600;
	// single sided image, half of that
	localparam int SS_IMAGE_WORDS = 204800;

	// prefix of the ROM and download area
	localparam logic [3:0] ROM_REGION = 4'b0001;
	// RAM sits at the bottom of the SDRAM
	localparam logic [2:0] RAM_REGION = 3'b000;

	// host download index values
	localparam logic [7:0] IDX_ROM        = 8'd0;
	localparam logic [7:0] IDX_FLOPPY_INT = 8'd1;
	localparam logic [7:0] IDX_FLOPPY_EXT = 8'd2;

	//==========================================================
	// SDRAM address decoding
	//==========================================================

	// ROM layout with the model bit choosing the ROM image
	typedef struct packed {
		logic [3:0]  region;
		logic [1:0]  zero;
		logic        model;
		logic [17:0] word;
	} rom_addr_t;

	// RAM layout with the disk image area above plain RAM
	typedef struct packed {
		logic [2:0]  region;
		logic        disk;
		logic [20:0] word;
	} ram_addr_t;

	// same SDRAM word address seen in the ROM or the RAM layout
	typedef union packed {
		sdram_addr_t raw;
		rom_addr_t   rom_view;
		ram_addr_t   ram_view;
	} sdram_addr_u;

	//==========================================================
	// request bundles
	//==========================================================

	// word assembled from the host download stream
	typedef struct packed {
		dio_addr_t addr;
		word_t     data;
		logic      write;
	} dio_word_t;

	// chipset memory request, strobes and enables active low
	typedef struct packed {
		mem_addr_t addr;
		word_t     wdata;
		logic      uds_n;
		logic      lds_n;
		logic      rom_oe_n;
		logic      ram_oe_n;
		logic      ram_we_n;
		logic      dsk_ack;
	} mem_req_t;

	// request seen by the SDRAM controller
	typedef struct packed {
		sdram_addr_u addr;
		word_t       din;
		logic [1:0]  ds;
		logic        we;
		logic        oe;
	} sdram_req_t;

endpackage

`default_nettype wire

// ==== logic/sdram_port_mux.sv ====
//==========================================================
// SDRAM port selection
// a download slot puts the pending download word on the
// port, every other cycle carries the chipset request in
// the ROM or RAM layout; disk image reads are byte wide
// and get demultiplexed here, purely combinational
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module sdram_port_mux import mac_mem_pkg::*; (
	input  wire logic      ioctl_download,
	input  wire logic      dio_slot,
	input  wire logic      model,
	input  wire dio_word_t dio,
	input  wire mem_req_t  mem_req,
	input  wire word_t     sdram_out,
	output sdram_req_t     sdram_req,
	output word_t          mem_rdata
);

	logic  download_cycle;
	logic  rom_rd;
	logic  dsk_rd;
	// byte of a disk image word, copied into both halves
	word_t dsk_byte;

	assign download_cycle = ioctl_download & dio_slot;
	assign rom_rd         = ~mem_req.rom_oe_n;
	assign dsk_rd         = mem_req.dsk_ack;

	// even byte addresses hold the upper byte
	always_comb begin
		if (mem_req.addr[0]) begin
			dsk_byte = {sdram_out[7:0], sdram_out[7:0]};
		end else begin
			dsk_byte = {sdram_out[15:8], sdram_out[15:8]};
		end
	end

	//==========================================================
	// request and read data select
	//==========================================================

	always_comb begin
		if (download_cycle) begin
			// download area starts right at the ROM region
			sdram_req.addr.raw = {ROM_REGION, dio.addr};
			sdram_req.din      = dio.data;
			sdram_req.ds       = 2'b11;
			sdram_req.we       = dio.write;
			sdram_req.oe       = 1'b0;
			// all ones keeps the screen black while loading
			mem_rdata          = '1;
		end else begin
			if (rom_rd) begin
				sdram_req.addr.rom_view.region = ROM_REGION;
				sdram_req.addr.rom_view.zero   = 2'b00;
				sdram_req.addr.rom_view.model  = model;
				sdram_req.addr.rom_view.word   = mem_req.addr[18:1];
			end else begin
				// disk reads go to the image area above RAM
				sdram_req.addr.ram_view.region = RAM_REGION;
				sdram_req.addr.ram_view.disk   = dsk_rd;
				sdram_req.addr.ram_view.word   = mem_req.addr[21:1];
			end
			sdram_req.din = mem_req.wdata;
			sdram_req.ds  = {~mem_req.uds_n, ~mem_req.lds_n};
			sdram_req.we  = ~mem_req.ram_we_n;
			sdram_req.oe  = ~mem_req.ram_oe_n | rom_rd | dsk_rd;

			if (dsk_rd) begin
				mem_rdata = dsk_byte;
			end else begin
				mem_rdata = sdram_out;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mac_mem_front.f ====
logic/mac_mem_pkg.sv
logic/image_loader.sv
logic/floppy_detect.sv
logic/sdram_port_mux.sv
logic/mac_mem_front.sv
verification/tb_mac_mem_front.sv

// ==== verification/tb_mac_mem_front.sv ====
//==========================================================
// directed testbench for the memory front end
// drives host downloads, download slots, chipset requests
// and disk signals, then prints one line per test and a
// closing line with the counts
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module tb_mac_mem_front import mac_mem_pkg::*; ();

	localparam int LED_HOLD   = 20;
	localparam int WAIT_LIMIT = 16;

	logic        clk_sys;
	logic        rst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	word_t       ioctl_data;
	logic        ioctl_wait;
	logic        dio_slot;
	logic        model;
	mem_req_t    mem_req;
	word_t       sdram_out;
	sdram_req_t  sdram_req;
	word_t       mem_rdata;
	logic [1:0]  disk_eject;
	logic [1:0]  disk_act;
	logic [1:0]  disk_ins;
	logic [1:0]  disk_sides;
	logic        led_user;

	logic [31:0] rng;
	string       cur_test;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;

	mac_mem_front #(
		.ACT_HOLD (LED_HOLD)
	) u_mac_mem_front (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.dio_slot       (dio_slot),
		.model          (model),
		.mem_req        (mem_req),
		.sdram_out      (sdram_out),
		.sdram_req      (sdram_req),
		.mem_rdata      (mem_rdata),
		.disk_eject     (disk_eject),
		.disk_act       (disk_act),
		.disk_ins       (disk_ins),
		.disk_sides     (disk_sides),
		.led_user       (led_user)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//==========================================================
	// helpers
	//==========================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// let combinational paths settle before sampling
	task automatic settle();
		#10;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", cur_test, what);
		errors++;
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
		end
		$display("test %s finished, %0d error(s)", cur_test, errors - test_errors);
	endtask

	task automatic wait_host_release();
		int n;
		n = 0;
		while (ioctl_wait && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (ioctl_wait)
			report_failure("ioctl_wait never cleared after the download slot");
	endtask

	// one host word through strobe, slot and release, checking the download cycle
	task automatic push_word(input logic [24:0] a, input word_t d,
			input logic [24:0] exp_addr);
		ioctl_addr = a;
		ioctl_data = d;
		ioctl_wr   = 1'b1;
		tick();
		ioctl_wr = 1'b0;
		// slot stays low one cycle so the write level follows the wait level
		tick();
		dio_slot = 1'b1;
		settle();
		if (sdram_req.addr.raw !== exp_addr)
			report_mismatch("addr", exp_addr, sdram_req.addr.raw);
		if (sdram_req.din !== {d[7:0], d[15:8]})
			report_mismatch("din", {d[7:0], d[15:8]}, sdram_req.din);
		if (sdram_req.ds !== 2'b11)
			report_mismatch("ds", 2'b11, sdram_req.ds);
		if (sdram_req.we !== 1'b1)
			report_mismatch("we", 1'b1, sdram_req.we);
		if (sdram_req.oe !== 1'b0)
			report_mismatch("oe", 1'b0, sdram_req.oe);
		if (mem_rdata !== 16'hffff)
			report_mismatch("rdata", 16'hffff, mem_rdata);
		tick();
		dio_slot = 1'b0;
		wait_host_release();
	endtask

	//==========================================================
	// tests
	//==========================================================

	task automatic test_rom_download();
		logic [7:0] idx;
		begin_test("rom_download");
		ioctl_download = 1'b1;
		for (int i = 0; i < 4; i++) begin
			// index bit 6 picks the second ROM bank
			idx         = (i < 2) ? IDX_ROM : 8'h40;
			ioctl_index = idx;
			rng = xorshift(rng);
			push_word(rng[24:0], rng[31:16], {ROM_REGION, 2'b00, idx[6], rng[18:1]});
		end
		end_test();
	endtask

	task automatic test_wait_behavior();
		begin_test("wait_behavior");
		rng = xorshift(rng);
		ioctl_addr = rng[24:0];
		ioctl_data = rng[15:0];
		ioctl_wr   = 1'b1;
		tick();
		ioctl_wr = 1'b0;
		if (ioctl_wait !== 1'b1)
			report_mismatch("wait after strobe", 1'b1, ioctl_wait);
		for (int i = 0; i < 6; i++) begin
			tick();
			if (ioctl_wait !== 1'b1)
				report_mismatch("wait without slot", 1'b1, ioctl_wait);
		end
		dio_slot = 1'b1;
		tick();
		dio_slot = 1'b0;
		wait_host_release();
		ioctl_download = 1'b0;
		tick();
		end_test();
	endtask

	task automatic floppy_load(input logic [7:0] idx, input logic [24:0] last_addr);
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		rng = xorshift(rng);
		push_word(rng[24:0], rng[31:16], {ROM_REGION, idx[1:0], rng[19:1]});
		rng = xorshift(rng);
		push_word(last_addr, rng[15:0], {ROM_REGION, idx[1:0], last_addr[19:1]});
		ioctl_download = 1'b0;
		tick();
	endtask

	task automatic check_drives(input logic [1:0] ins, input logic [1:0] sides);
		if (disk_ins !== ins)
			report_mismatch("disk_ins", ins, disk_ins);
		if (disk_sides !== sides)
			report_mismatch("disk_sides", sides, disk_sides);
	endtask

	task automatic test_floppy_detect();
		begin_test("floppy_detect");
		// image sizes arrive as byte addresses
		floppy_load(IDX_FLOPPY_INT, 25'(2 * 409600));
		check_drives(2'b01, 2'b01);
		floppy_load(IDX_FLOPPY_EXT, 25'(2 * 204800));
		check_drives(2'b11, 2'b01);
		// ejecting the external drive leaves the internal one alone
		disk_eject = 2'b10;
		tick();
		disk_eject = 2'b00;
		check_drives(2'b01, 2'b01);
		floppy_load(IDX_FLOPPY_INT, 25'(2 * 300000));
		check_drives(2'b00, 2'b00);
		end_test();
	endtask

	task automatic test_chipset_path();
		logic [24:0] exp_addr;
		begin_test("chipset_path");
		tick();
		rng = xorshift(rng);
		mem_req.addr     = rng[21:0];
		mem_req.rom_oe_n = 1'b0;
		mem_req.uds_n    = 1'b0;
		mem_req.lds_n    = 1'b0;
		rng = xorshift(rng);
		sdram_out = rng[15:0];
		// both ROM images, the model bit picks one
		for (int m = 0; m < 2; m++) begin
			tick();
			model = m[0];
			settle();
			exp_addr = {ROM_REGION, 2'b00, m[0], mem_req.addr[18:1]};
			if (sdram_req.addr.raw !== exp_addr)
				report_mismatch("rom addr", exp_addr, sdram_req.addr.raw);
			if (sdram_req.oe !== 1'b1)
				report_mismatch("rom oe", 1'b1, sdram_req.oe);
			if (sdram_req.ds !== 2'b11)
				report_mismatch("rom ds", 2'b11, sdram_req.ds);
			if (mem_rdata !== sdram_out)
				report_mismatch("rom rdata", sdram_out, mem_rdata);
		end
		// RAM write of the upper byte
		tick();
		mem_req.rom_oe_n = 1'b1;
		mem_req.ram_we_n = 1'b0;
		mem_req.lds_n    = 1'b1;
		mem_req.wdata    = rng[31:16];
		settle();
		exp_addr = {RAM_REGION, 1'b0, mem_req.addr[21:1]};
		if (sdram_req.addr.raw !== exp_addr)
			report_mismatch("ram addr", exp_addr, sdram_req.addr.raw);
		if (sdram_req.we !== 1'b1)
			report_mismatch("ram we", 1'b1, sdram_req.we);
		if (sdram_req.ds !== 2'b10)
			report_mismatch("ram ds upper", 2'b10, sdram_req.ds);
		if (sdram_req.din !== rng[31:16])
			report_mismatch("ram din", rng[31:16], sdram_req.din);
		tick();
		mem_req.uds_n = 1'b1;
		mem_req.lds_n = 1'b0;
		settle();
		if (sdram_req.ds !== 2'b01)
			report_mismatch("ram ds lower", 2'b01, sdram_req.ds);
		if (mem_rdata !== sdram_out)
			report_mismatch("ram rdata", sdram_out, mem_rdata);
		tick();
		mem_req.ram_we_n = 1'b1;
		mem_req.lds_n    = 1'b1;
		end_test();
	endtask

	task automatic test_disk_bytes();
		word_t exp_data;
		begin_test("disk_bytes");
		mem_req.dsk_ack  = 1'b1;
		mem_req.ram_oe_n = 1'b0;
		for (int i = 0; i < 2; i++) begin
			rng = xorshift(rng);
			mem_req.addr = {rng[21:1], i[0]};
			sdram_out    = rng[31:16];
			settle();
			// even byte address reads the upper byte
			exp_data = i[0] ? {rng[23:16], rng[23:16]} : {rng[31:24], rng[31:24]};
			if (sdram_req.addr.raw[21] !== 1'b1)
				report_mismatch("disk bit", 1'b1, sdram_req.addr.raw[21]);
			if (mem_rdata !== exp_data)
				report_mismatch("disk rdata", exp_data, mem_rdata);
			tick();
		end
		mem_req.dsk_ack  = 1'b0;
		mem_req.ram_oe_n = 1'b1;
		end_test();
	endtask

	task automatic test_activity_led();
		int n;
		begin_test("activity_led");
		ioctl_index    = IDX_ROM;
		ioctl_download = 1'b1;
		settle();
		if (led_user !== 1'b1)
			report_mismatch("led while loading", 1'b1, led_user);
		tick();
		ioctl_download = 1'b0;
		tick();
		if (led_user !== 1'b0)
			report_mismatch("led idle", 1'b0, led_user);
		disk_act = 2'b01;
		settle();
		if (led_user !== 1'b0)
			report_mismatch("led before edge", 1'b0, led_user);
		tick();
		disk_act = 2'b00;
		n = 0;
		while (led_user && n < 4 * LED_HOLD) begin
			n++;
			tick();
		end
		if (led_user)
			report_failure("led_user stayed on after the activity hold");
		else if (n != LED_HOLD)
			report_mismatch("led cycles", LED_HOLD, n);
		end_test();
	endtask

	//==========================================================
	// main sequence
	//==========================================================

	initial begin
		rng            = 32'h4c3d_ff3e;
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = IDX_ROM;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		dio_slot       = 1'b0;
		model          = 1'b0;
		mem_req        = '0;
		mem_req.uds_n    = 1'b1;
		mem_req.lds_n    = 1'b1;
		mem_req.rom_oe_n = 1'b1;
		mem_req.ram_oe_n = 1'b1;
		mem_req.ram_we_n = 1'b1;
		sdram_out      = '0;
		disk_eject     = 2'b00;
		disk_act       = 2'b00;
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		begin_test("reset_state");
		if (ioctl_wait !== 1'b0)
			report_mismatch("ioctl_wait", 1'b0, ioctl_wait);
		if (u_mac_mem_front.dio.write !== 1'b0)
			report_mismatch("dio.write", 1'b0, u_mac_mem_front.dio.write);
		check_drives(2'b00, 2'b00);
		if (led_user !== 1'b0)
			report_mismatch("led_user", 1'b0, led_user);
		end_test();

		test_rom_download();
		test_wait_behavior();
		test_floppy_detect();
		test_chipset_path();
		test_disk_bytes();
		test_activity_led();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
